/* logic/neoIoMapPkg.sv */
// Register map and bus constants, imported by the system I/O RTL and its testbench
`default_nettype none

package neoIoMapPkg;

	// ==========================================================
	// APB slave port
	// ==========================================================

	// Byte address, registers on word boundaries
	localparam int ApbAddrWidth = 8;

	// ==========================================================
	// Register offsets
	// ==========================================================

	// Read-only inputs
	localparam logic [ApbAddrWidth-1:0] RegDipSw = 8'h00;
	localparam logic [ApbAddrWidth-1:0] RegSysType = 8'h04;
	// Coins, service, RTC serial pins
	localparam logic [ApbAddrWidth-1:0] RegStatusA = 8'h08;

	// Writable control
	localparam logic [ApbAddrWidth-1:0] RegSlot = 8'h10;
	// LED latch strobes, field in bits 5..3
	localparam logic [ApbAddrWidth-1:0] RegLedLatch = 8'h14;
	localparam logic [ApbAddrWidth-1:0] RegLedData = 8'h18;
	// RTC bit-bang pins
	localparam logic [ApbAddrWidth-1:0] RegRtcCtrl = 8'h1C;

	// ==========================================================
	// Input synchronizer
	// ==========================================================

	// Two flops is enough for switches and RTC data
	localparam int DefSyncStages = 2;

endpackage

`default_nettype wire

/* logic/neoIoFieldPkg.sv */
// Register field layout and write byte views, imported by the I/O register RTL and testbench
`default_nettype none

package neoIoFieldPkg;

	// ==========================================================
	// Field widths
	// ==========================================================

	// One data byte per register
	localparam int IoByteWidth = 8;
	localparam int NumCoins = 4;

	// Cartridge slots, multi-slot boards only
	localparam int SlotWidth = 3;
	localparam int NumSlots = 6;

	// Strobe field sits in bits 5..3
	localparam int LedLatchWidth = 3;
	localparam int LedLatchLsb = 3;

	// Strobe, clock, data in
	localparam int RtcCtrlWidth = 3;

	// ==========================================================
	// Status A bit positions
	// ==========================================================

	localparam int StatRtcDout = 7;
	localparam int StatRtcTp = 6;
	// Always reads as one on an arcade board
	localparam int StatFixedOne = 5;
	localparam int StatCoin4 = 4;
	localparam int StatCoin3 = 3;
	localparam int StatService = 2;
	localparam int StatCoin2 = 1;
	localparam int StatCoin1 = 0;

	// ==========================================================
	// Write byte, decoded per target register
	// ==========================================================

	typedef union packed {
		struct packed {
			logic [IoByteWidth-SlotWidth-1:0] unused;
			logic [SlotWidth-1:0] slot;
		} slotView;
		struct packed {
			logic [IoByteWidth-LedLatchWidth-LedLatchLsb-1:0] unusedHi;
			logic [LedLatchWidth-1:0] strobe;
			logic [LedLatchLsb-1:0] unusedLo;
		} latchView;
		struct packed {
			logic [IoByteWidth-RtcCtrlWidth-1:0] unused;
			logic strobe;
			logic clk;
			logic din;
		} rtcView;
	} IoWriteByte_u;

endpackage

`default_nettype wire

/* logic/neoInputSync.sv */
// Synchronizer chain for the board switch, coin and RTC input pins, feeding the register block
`timescale 1ns/1ps
`default_nettype none

module neoInputSync #(
	parameter int syncStages = neoIoMapPkg::DefSyncStages
) (
	input wire clk,
	input wire nRESET,
	// Raw board pins, asynchronous to clk
	input wire [neoIoFieldPkg::IoByteWidth-1:0] dipSw,
	input wire [neoIoFieldPkg::NumCoins-1:0] coin,
	input wire service,
	input wire test,
	input wire rtcDout,
	input wire rtcTp,
	// Pins after the last stage
	output logic [neoIoFieldPkg::IoByteWidth-1:0] syncDipSw,
	output logic [neoIoFieldPkg::NumCoins-1:0] syncCoin,
	output logic syncService,
	output logic syncTest,
	output logic syncRtcDout,
	output logic syncRtcTp
);

	import neoIoFieldPkg::*;

	// DIP byte, coins, then four single pins
	localparam int InWidth = IoByteWidth + NumCoins + 4;

	logic [InWidth-1:0] pinBus;
	logic [syncStages-1:0][InWidth-1:0] chain;

	// All pins share one chain
	assign pinBus = {dipSw, coin, service, test, rtcDout, rtcTp};

	// ==========================================================
	// Shift chain
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (!nRESET)
		begin
			chain <= '0;
		end
		else
		begin
			// First stage samples the pins
			chain[0] <= pinBus;
			// Remaining stages shift toward the output
			for (int i = 1; i < syncStages; i++)
			begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// Split the last stage back into fields
	assign {syncDipSw, syncCoin, syncService, syncTest, syncRtcDout, syncRtcTp} =
		chain[syncStages-1];

endmodule

`default_nettype wire

/* logic/neoIoRegs.sv */
// APB register block for the system I/O, holding slot, LED and RTC state and muxing read data
`timescale 1ns/1ps
`default_nettype none

module neoIoRegs (
	input wire clk,
	input wire nRESET,
	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [neoIoMapPkg::ApbAddrWidth-1:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// Synchronized board inputs
	input wire [neoIoFieldPkg::IoByteWidth-1:0] syncDipSw,
	input wire [neoIoFieldPkg::NumCoins-1:0] syncCoin,
	input wire syncService,
	input wire syncTest,
	input wire syncRtcDout,
	input wire syncRtcTp,
	// High on arcade boards, low on consoles
	input wire systemType,
	// Control state
	output logic [neoIoFieldPkg::SlotWidth-1:0] slotReg,
	output logic [neoIoFieldPkg::LedLatchWidth-1:0] ledLatch,
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledData,
	// RTC bit-bang pins
	output logic rtcDin,
	output logic rtcClk,
	output logic rtcStrobe
);

	import neoIoMapPkg::*;
	import neoIoFieldPkg::*;

	logic access;
	logic isMapped;
	logic isReadOnly;
	logic wrValid;
	IoWriteByte_u wrByte;
	IoWriteByte_u rdView;
	logic [IoByteWidth-1:0] rdByte;
	logic [IoByteWidth-1:0] statusA;
	// strobe, clk, din
	logic [RtcCtrlWidth-1:0] rtcCtrl;

	// ==========================================================
	// Bus decode
	// ==========================================================

	// Second cycle of a transfer
	assign access = psel & penable;

	// Never any wait states
	assign pready = 1'b1;

	// Low byte carries all write fields
	assign wrByte = pwdata[IoByteWidth-1:0];

	// Status A as seen on an arcade board
	always_comb
	begin
		statusA = '0;
		statusA[StatRtcDout] = syncRtcDout;
		statusA[StatRtcTp] = syncRtcTp;
		statusA[StatFixedOne] = 1'b1;
		statusA[StatCoin4] = syncCoin[3];
		statusA[StatCoin3] = syncCoin[2];
		statusA[StatService] = syncService;
		statusA[StatCoin2] = syncCoin[1];
		statusA[StatCoin1] = syncCoin[0];
	end

	// Address decode and read mux
	always_comb
	begin
		rdView = '0;
		rdByte = '0;
		isMapped = 1'b1;
		isReadOnly = 1'b0;
		case (paddr)
			RegDipSw:
			begin
				rdByte = syncDipSw;
				isReadOnly = 1'b1;
			end
			RegSysType:
			begin
				// Test button in bit 7, rest reads zero
				rdByte = {syncTest, {(IoByteWidth-1){1'b0}}};
				isReadOnly = 1'b1;
			end
			RegStatusA:
			begin
				// Console reads zero, BIOS uses this to tell the boards apart
				rdByte = systemType ? statusA : '0;
				isReadOnly = 1'b1;
			end
			RegSlot:
			begin
				rdView.slotView.slot = slotReg;
				rdByte = rdView;
			end
			RegLedLatch:
			begin
				// Back in the same bit positions as written
				rdView.latchView.strobe = ledLatch;
				rdByte = rdView;
			end
			RegLedData:
			begin
				rdByte = ledData;
			end
			RegRtcCtrl:
			begin
				rdView.rtcView.strobe = rtcCtrl[2];
				rdView.rtcView.clk = rtcCtrl[1];
				rdView.rtcView.din = rtcCtrl[0];
				rdByte = rdView;
			end
			default:
			begin
				isMapped = 1'b0;
			end
		endcase
	end

	// Error on a hole in the map or a write to an input register
	assign pslverr = access & (~isMapped | (pwrite & isReadOnly));

	// Zero-extended, only driven in a read access
	assign prdata = (access && !pwrite) ? {{(32-IoByteWidth){1'b0}}, rdByte} : '0;

	// Faulted writes change nothing
	assign wrValid = access & pwrite & isMapped & ~isReadOnly;

	// ==========================================================
	// Writable registers
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (!nRESET)
		begin
			slotReg <= '0;
			ledLatch <= '0;
			ledData <= '0;
			rtcCtrl <= '0;
		end
		else if (wrValid)
		begin
			case (paddr)
				RegSlot:
					slotReg <= wrByte.slotView.slot;
				RegLedLatch:
					ledLatch <= wrByte.latchView.strobe;
				// Whole byte, no field view
				RegLedData:
					ledData <= wrByte;
				RegRtcCtrl:
					rtcCtrl <= {wrByte.rtcView.strobe, wrByte.rtcView.clk, wrByte.rtcView.din};
				default:
					slotReg <= slotReg;
			endcase
		end
	end

	// RTC pins straight off the register
	assign rtcDin = rtcCtrl[0];
	assign rtcClk = rtcCtrl[1];
	assign rtcStrobe = rtcCtrl[2];

endmodule

`default_nettype wire

/* logic/neoSlotSelect.sv */
// Cartridge slot decoder, turns the slot register into registered enables and slot lines
`timescale 1ns/1ps
`default_nettype none

module neoSlotSelect (
	input wire clk,
	input wire nRESET,
	// Slot number from the register block
	input wire [neoIoFieldPkg::SlotWidth-1:0] slotReg,
	// High on multi-slot boards
	input wire systemB,
	// One-hot active-low slot enables
	output logic [neoIoFieldPkg::NumSlots-1:0] nSlot,
	// Binary slot number
	output logic slotA,
	output logic slotB,
	output logic slotC
);

	import neoIoFieldPkg::*;

	logic [NumSlots-1:0] slotDec;

	// ==========================================================
	// Enable decode
	// ==========================================================

	always_comb
	begin
		// Default all slots off
		slotDec = '1;
		// Numbers past the last slot leave every enable high
		if (slotReg < NumSlots)
		begin
			slotDec[slotReg] = 1'b0;
		end
	end

	// ==========================================================
	// Output registers
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (!nRESET)
		begin
			nSlot <= '1;
			{slotC, slotB, slotA} <= '0;
		end
		else if (systemB)
		begin
			nSlot <= slotDec;
			// Slot lines carry the number even when out of range
			{slotC, slotB, slotA} <= slotReg;
		end
		else
		begin
			// Single-slot board, nothing to select
			nSlot <= '1;
			{slotC, slotB, slotA} <= '0;
		end
	end

endmodule

`default_nettype wire

/* logic/neoLedLatches.sv */
// Display latch model, captures LED data into three bytes on rising latch strobes
`timescale 1ns/1ps
`default_nettype none

module neoLedLatches (
	input wire clk,
	input wire nRESET,
	// Strobes, one per display byte
	input wire [neoIoFieldPkg::LedLatchWidth-1:0] ledLatch,
	// Shared data byte for all displays
	input wire [neoIoFieldPkg::IoByteWidth-1:0] ledData,
	// Latched display bytes
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledOut0,
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledOut1,
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledOut2
);

	import neoIoFieldPkg::*;

	logic [LedLatchWidth-1:0] prevLatch;
	logic [LedLatchWidth-1:0] risingEdge;
	logic [LedLatchWidth-1:0][IoByteWidth-1:0] display;

	// ==========================================================
	// Strobe edge detect
	// ==========================================================

	// 0 to 1 since last cycle
	assign risingEdge = ledLatch & ~prevLatch;

	// ==========================================================
	// Capture
	// ==========================================================

	always_ff @(posedge clk)
	begin
		if (!nRESET)
		begin
			prevLatch <= '0;
			display <= '0;
		end
		else
		begin
			prevLatch <= ledLatch;
			// Bit i loads display byte i
			for (int i = 0; i < LedLatchWidth; i++)
			begin
				if (risingEdge[i])
				begin
					display[i] <= ledData;
				end
			end
		end
	end

	// Byte 0 on strobe bit 0, and so on
	assign ledOut0 = display[0];
	assign ledOut1 = display[1];
	assign ledOut2 = display[2];

endmodule

`default_nettype wire

/* logic/neoSysIo.sv */
// System I/O top level, an APB peripheral for the arcade board's switches, slots, LEDs and RTC
`timescale 1ns/1ps
`default_nettype none

module neoSysIo #(
	// Input synchronizer depth
	parameter int syncStages = neoIoMapPkg::DefSyncStages
) (
	input wire clk,
	input wire nRESET,
	// APB slave
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [neoIoMapPkg::ApbAddrWidth-1:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// Board inputs
	input wire [neoIoFieldPkg::IoByteWidth-1:0] dipSw,
	input wire coin1,
	input wire coin2,
	input wire coin3,
	input wire coin4,
	input wire service,
	input wire test,
	input wire rtcDout,
	input wire rtcTp,
	input wire systemType,
	input wire systemB,
	// Slot select
	output logic [neoIoFieldPkg::NumSlots-1:0] nSlot,
	output logic slotA,
	output logic slotB,
	output logic slotC,
	// LED latch interface and display bytes
	output logic [neoIoFieldPkg::LedLatchWidth-1:0] ledLatch,
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledData,
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledOut0,
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledOut1,
	output logic [neoIoFieldPkg::IoByteWidth-1:0] ledOut2,
	// RTC
	output logic rtcDin,
	output logic rtcClk,
	output logic rtcStrobe
);

	import neoIoFieldPkg::*;

	logic [IoByteWidth-1:0] syncDipSw;
	logic [NumCoins-1:0] syncCoin;
	logic syncService;
	logic syncTest;
	logic syncRtcDout;
	logic syncRtcTp;
	logic [SlotWidth-1:0] slotReg;

	// ==========================================================
	// Input side
	// ==========================================================

	neoInputSync #(
		.syncStages(syncStages)
	) inputSync (
		.clk(clk),
		.nRESET(nRESET),
		.dipSw(dipSw),
		// Coin 1 in bit 0
		.coin({coin4, coin3, coin2, coin1}),
		.service(service),
		.test(test),
		.rtcDout(rtcDout),
		.rtcTp(rtcTp),
		.syncDipSw(syncDipSw),
		.syncCoin(syncCoin),
		.syncService(syncService),
		.syncTest(syncTest),
		.syncRtcDout(syncRtcDout),
		.syncRtcTp(syncRtcTp)
	);

	// ==========================================================
	// Registers and output stages
	// ==========================================================

	neoIoRegs ioRegs (
		.clk(clk),
		.nRESET(nRESET),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.syncDipSw(syncDipSw),
		.syncCoin(syncCoin),
		.syncService(syncService),
		.syncTest(syncTest),
		.syncRtcDout(syncRtcDout),
		.syncRtcTp(syncRtcTp),
		.systemType(systemType),
		.slotReg(slotReg),
		.ledLatch(ledLatch),
		.ledData(ledData),
		.rtcDin(rtcDin),
		.rtcClk(rtcClk),
		.rtcStrobe(rtcStrobe)
	);

	neoSlotSelect slotSelect (
		.clk(clk),
		.nRESET(nRESET),
		.slotReg(slotReg),
		.systemB(systemB),
		.nSlot(nSlot),
		.slotA(slotA),
		.slotB(slotB),
		.slotC(slotC)
	);

	// Stands in for the external latch chips
	neoLedLatches ledLatches (
		.clk(clk),
		.nRESET(nRESET),
		.ledLatch(ledLatch),
		.ledData(ledData),
		.ledOut0(ledOut0),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2)
	);

endmodule

`default_nettype wire

/* sim/neoSysIoTb.sv */
// Self-checking random testbench for the system I/O block, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module neoSysIoTb;

	import neoIoMapPkg::*;
	import neoIoFieldPkg::*;

	localparam int SyncStages = DefSyncStages;
	localparam int ResetCycles = 4;
	localparam int NumInputRounds = 8;
	localparam int NumSlotWrites = 16;
	localparam int NumLedRounds = 12;
	localparam int NumRtcWrites = 10;
	localparam int NumErrors = 12;
	// Input rounds read three registers
	// Slot and LED rounds do two transfers each
	localparam int TotalXfers = 3 * NumInputRounds + 2 * NumSlotWrites + 2 * NumLedRounds
		+ NumRtcWrites + 4 + NumErrors + 4;
	localparam int TimeoutCycles = 20 * TotalXfers + ResetCycles;

	logic clk;
	logic nRESET;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ApbAddrWidth-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [IoByteWidth-1:0] dipSw;
	logic coin1;
	logic coin2;
	logic coin3;
	logic coin4;
	logic service;
	logic test;
	logic rtcDout;
	logic rtcTp;
	logic systemType;
	logic systemB;
	logic [NumSlots-1:0] nSlot;
	logic slotA;
	logic slotB;
	logic slotC;
	logic [LedLatchWidth-1:0] ledLatch;
	logic [IoByteWidth-1:0] ledData;
	logic [IoByteWidth-1:0] ledOut0;
	logic [IoByteWidth-1:0] ledOut1;
	logic [IoByteWidth-1:0] ledOut2;
	logic rtcDin;
	logic rtcClk;
	logic rtcStrobe;

	integer seed;
	int cycleCount;

	// Model state
	logic [SlotWidth-1:0] mSlot;
	logic [LedLatchWidth-1:0] mLatch;
	logic [IoByteWidth-1:0] mData;
	// strobe, clk, din
	logic [RtcCtrlWidth-1:0] mRtc;
	logic [LedLatchWidth-1:0][IoByteWidth-1:0] mOut;

	neoSysIo #(
		.syncStages(SyncStages)
	) UUT (
		.clk(clk),
		.nRESET(nRESET),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.dipSw(dipSw),
		.coin1(coin1),
		.coin2(coin2),
		.coin3(coin3),
		.coin4(coin4),
		.service(service),
		.test(test),
		.rtcDout(rtcDout),
		.rtcTp(rtcTp),
		.systemType(systemType),
		.systemB(systemB),
		.nSlot(nSlot),
		.slotA(slotA),
		.slotB(slotB),
		.slotC(slotC),
		.ledLatch(ledLatch),
		.ledData(ledData),
		.ledOut0(ledOut0),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2),
		.rtcDin(rtcDin),
		.rtcClk(rtcClk),
		.rtcStrobe(rtcStrobe)
	);

	// ==========================================================
	// Clock and run limit
	// ==========================================================

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		stopRun("Timeout, the run went past its cycle limit");
	end

	// ==========================================================
	// Reporting
	// ==========================================================

	task automatic stopRun(input string reason);
		$display("Test failures found");
		$fatal(1, "%s", reason);
	endtask

	task automatic expectEqual(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			stopRun("A checked value did not match the model");
		end
	endtask

	// ==========================================================
	// Register map model
	// ==========================================================

	function automatic logic isMappedAddr(input logic [ApbAddrWidth-1:0] addr);
		case (addr)
			RegDipSw, RegSysType, RegStatusA, RegSlot, RegLedLatch, RegLedData, RegRtcCtrl:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic isReadOnlyAddr(input logic [ApbAddrWidth-1:0] addr);
		return (addr == RegDipSw) || (addr == RegSysType) || (addr == RegStatusA);
	endfunction

	// Expected read word from the driven pins and the model
	function automatic logic [31:0] expectedRead(input logic [ApbAddrWidth-1:0] addr);
		logic [31:0] word;
		word = '0;
		case (addr)
			RegDipSw:
				word[IoByteWidth-1:0] = dipSw;
			RegSysType:
				word[7] = test;
			RegStatusA:
			begin
				// Console reads all zero
				if (systemType)
				begin
					word[StatRtcDout] = rtcDout;
					word[StatRtcTp] = rtcTp;
					word[StatFixedOne] = 1'b1;
					word[StatCoin4] = coin4;
					word[StatCoin3] = coin3;
					word[StatService] = service;
					word[StatCoin2] = coin2;
					word[StatCoin1] = coin1;
				end
			end
			RegSlot:
				word[SlotWidth-1:0] = mSlot;
			RegLedLatch:
				word[LedLatchLsb +: LedLatchWidth] = mLatch;
			RegLedData:
				word[IoByteWidth-1:0] = mData;
			RegRtcCtrl:
				word[RtcCtrlWidth-1:0] = mRtc;
			default:
				word = '0;
		endcase
		return word;
	endfunction

	task automatic applyWrite(input logic [ApbAddrWidth-1:0] addr, input logic [7:0] data);
		logic [LedLatchWidth-1:0] newLatch;
		newLatch = data[LedLatchLsb +: LedLatchWidth];
		case (addr)
			RegSlot:
				mSlot = data[SlotWidth-1:0];
			RegLedLatch:
			begin
				// Rising strobe bits grab the current data byte
				for (int i = 0; i < LedLatchWidth; i++)
				begin
					if (newLatch[i] && !mLatch[i])
						mOut[i] = mData;
				end
				mLatch = newLatch;
			end
			RegLedData:
				mData = data;
			RegRtcCtrl:
				mRtc = data[RtcCtrlWidth-1:0];
			default:
				mSlot = mSlot;
		endcase
	endtask

	// ==========================================================
	// Bus and pin stimulus
	// ==========================================================

	// Setup, access and idle cycle
	// Write lands on the edge that ends access
	task automatic apbXfer(input logic wr, input logic [ApbAddrWidth-1:0] addr,
		input logic [31:0] data);
		logic expErr;
		logic [31:0] expData;
		expErr = !isMappedAddr(addr) || (wr && isReadOnlyAddr(addr));
		expData = expectedRead(addr);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		// Mid access cycle
		@(negedge clk);
		expectEqual("pready", 32'd1, pready);
		expectEqual("pslverr", expErr, pslverr);
		if (!wr && !expErr)
			expectEqual("prdata", expData, prdata);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		if (wr && !expErr)
			applyWrite(addr, data[7:0]);
	endtask

	task automatic driveInputs(input logic arcade);
		logic [31:0] r;
		r = $random(seed);
		@(posedge clk);
		dipSw <= r[7:0];
		coin1 <= r[8];
		coin2 <= r[9];
		coin3 <= r[10];
		coin4 <= r[11];
		service <= r[12];
		test <= r[13];
		rtcDout <= r[14];
		rtcTp <= r[15];
		systemType <= arcade;
	endtask

	// ==========================================================
	// Output checks
	// ==========================================================

	task automatic slotOutputsMatch();
		logic [NumSlots-1:0] expNSlot;
		logic [SlotWidth-1:0] expLines;
		expNSlot = '1;
		expLines = '0;
		if (systemB)
		begin
			// 6 and 7 select nothing
			if (mSlot < NumSlots)
				expNSlot = ~(6'b1 << mSlot);
			expLines = mSlot;
		end
		expectEqual("nSlot", expNSlot, nSlot);
		expectEqual("slotCBA", expLines, {slotC, slotB, slotA});
	endtask

	task automatic verifyControlPins();
		expectEqual("ledLatch", mLatch, ledLatch);
		expectEqual("ledData", mData, ledData);
		expectEqual("rtcDin", mRtc[0], rtcDin);
		expectEqual("rtcClk", mRtc[1], rtcClk);
		expectEqual("rtcStrobe", mRtc[2], rtcStrobe);
	endtask

	task automatic compareDisplays();
		expectEqual("ledOut0", mOut[0], ledOut0);
		expectEqual("ledOut1", mOut[1], ledOut1);
		expectEqual("ledOut2", mOut[2], ledOut2);
	endtask

	task automatic readBackWritable();
		apbXfer(1'b0, RegSlot, 32'd0);
		apbXfer(1'b0, RegLedLatch, 32'd0);
		apbXfer(1'b0, RegLedData, 32'd0);
		apbXfer(1'b0, RegRtcCtrl, 32'd0);
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================

	initial
	begin
		logic [31:0] r;
		logic [ApbAddrWidth-1:0] addr;
		seed = 32'h2b7b_b57c;
		mSlot = '0;
		mLatch = '0;
		mData = '0;
		mRtc = '0;
		mOut = '0;
		nRESET = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dipSw = '0;
		{coin1, coin2, coin3, coin4} = 4'b0;
		{service, test, rtcDout, rtcTp} = 4'b0;
		systemType = 1'b0;
		// Multi-slot board through reset so the enables depend on reset
		systemB = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		nRESET <= 1'b1;

		// Reset values
		@(negedge clk);
		expectEqual("pslverr", 32'd0, pslverr);
		expectEqual("nSlot", {NumSlots{1'b1}}, nSlot);
		expectEqual("slotCBA", 32'd0, {slotC, slotB, slotA});
		verifyControlPins();
		compareDisplays();

		// Input registers with console and arcade alternating
		for (int i = 0; i < NumInputRounds; i++)
		begin
			driveInputs(i[0]);
			repeat (SyncStages + 2) @(posedge clk);
			apbXfer(1'b0, RegDipSw, 32'd0);
			apbXfer(1'b0, RegSysType, 32'd0);
			apbXfer(1'b0, RegStatusA, 32'd0);
		end

		// Slot decode
		// First eight sweep every number on a multi-slot board
		for (int i = 0; i < NumSlotWrites; i++)
		begin
			r = $random(seed);
			if (i < 8)
				r[2:0] = i[2:0];
			@(posedge clk);
			systemB <= r[8] | (i < 8);
			apbXfer(1'b1, RegSlot, r);
			repeat (2) @(posedge clk);
			@(negedge clk);
			slotOutputsMatch();
			apbXfer(1'b0, RegSlot, 32'd0);
		end

		// LED data then strobes
		for (int i = 0; i < NumLedRounds; i++)
		begin
			apbXfer(1'b1, RegLedData, $random(seed));
			@(negedge clk);
			verifyControlPins();
			apbXfer(1'b1, RegLedLatch, $random(seed));
			@(negedge clk);
			verifyControlPins();
			repeat (2) @(posedge clk);
			@(negedge clk);
			compareDisplays();
		end

		// RTC bit-bang
		for (int i = 0; i < NumRtcWrites; i++)
		begin
			apbXfer(1'b1, RegRtcCtrl, $random(seed));
			@(negedge clk);
			verifyControlPins();
		end
		readBackWritable();

		// Holes in the map and writes to inputs
		for (int i = 0; i < NumErrors; i++)
		begin
			r = $random(seed);
			if (r[31])
			begin
				addr = (r[9:8] == 2'd0) ? RegDipSw : (r[9:8] == 2'd1) ? RegSysType : RegStatusA;
				apbXfer(1'b1, addr, $random(seed));
			end
			else
			begin
				addr = r[7:0];
				while (isMappedAddr(addr))
					addr = addr + 8'd1;
				apbXfer(r[30], addr, $random(seed));
			end
		end
		@(negedge clk);
		verifyControlPins();
		compareDisplays();
		readBackWritable();

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* neoSysIo.f */
logic/neoIoMapPkg.sv
logic/neoIoFieldPkg.sv
logic/neoInputSync.sv
logic/neoIoRegs.sv
logic/neoSlotSelect.sv
logic/neoLedLatches.sv
logic/neoSysIo.sv
sim/neoSysIoTb.sv
